//--- include/bank_xor_macros.svh
/*
 Sizing of the banked scratchpad.
 NBANK must equal 2**LANE_BW, since the swap network addresses lanes by bit.
 SEL_BW must be wide enough to select any bit of a row address.
 Rotation stages move by 1, 2 and 4 positions.
*/
`ifndef BANK_XOR_MACROS_SVH
`define BANK_XOR_MACROS_SVH

// Banks and lanes are one to one
`define BX_NBANK 8
// Lane index width, also the number of swap stages
`define BX_LANE_BW 3
// Data bits per lane
`define BX_DATA_BW 16
// Row address, 16 rows per bank
`define BX_ROW_BW 4
// Selects one row bit per swap stage
`define BX_SEL_BW 2
// Omega stages after the swaps
`define BX_ROT_STAGES 3

`endif

//--- verilog/bank_xor_pkg.sv
/*
 Shared types of the banked scratchpad.
 Lane 0 sits in the low bits of a lane vector.
 A zero configuration is the identity placement.
*/
`include "bank_xor_macros.svh"
`default_nettype none

package bank_xor_pkg;

	//============================================================
	// Data vectors
	//============================================================
	// One word per lane, or per bank after the write network
	typedef logic [`BX_NBANK-1:0][`BX_DATA_BW-1:0] lane_vec_t;

	//============================================================
	// Scrambling configuration
	//============================================================
	typedef struct packed {
		// Row bit that enables swap stage s
		logic [`BX_LANE_BW-1:0][`BX_SEL_BW-1:0] swap_sel;
		// One enable per rotation stage
		logic [`BX_ROT_STAGES-1:0]              rot_mask;
	} xor_cfg_t;

	//============================================================
	// Requests
	//============================================================
	typedef struct packed {
		logic [`BX_ROW_BW-1:0] row;
		lane_vec_t             data;
	} wr_req_t;

	// Row only for now, room for more fields later
	typedef struct packed {
		logic [`BX_ROW_BW-1:0] row;
	} rd_req_t;

endpackage

`default_nettype wire

//--- verilog/bank_butterfly_write.sv
/*
 Lane to bank placement for one row, pure combinational logic.
 Swaps run from the low lane bit upward, each gated by a row bit.
 Rotations follow, each moving data by a power of two.
 Reading back needs the same configuration and the same row.
*/
`include "bank_xor_macros.svh"
`default_nettype none

module bank_butterfly_write
	import bank_xor_pkg::*;
(
	input  wire xor_cfg_t              i_cfg,
	input  wire [`BX_ROW_BW-1:0]       i_row,
	input  wire lane_vec_t             i_lanes,
	output lane_vec_t                  o_banks
);

	//============================================================
	// Stage vectors
	//============================================================
	localparam int NSTAGE = `BX_LANE_BW + `BX_ROT_STAGES;

	// Index 0 is the input, the last index is the bank order
	lane_vec_t stg [NSTAGE+1];
	// Swap enables, one per stage, decoded from the row
	logic [`BX_LANE_BW-1:0] swap_en;

	always_comb begin
		for (int s = 0; s < `BX_LANE_BW; s++) begin
			swap_en[s] = i_row[i_cfg.swap_sel[s]];
		end
	end

	//============================================================
	// Network
	//============================================================
	always_comb begin
		stg[0] = i_lanes;
		// Swap stages, lane j pairs with lane j xor 2^s
		for (int s = 0; s < `BX_LANE_BW; s++) begin
			for (int j = 0; j < `BX_NBANK; j++) begin
				if (swap_en[s])
					stg[s+1][j] = stg[s][j ^ (1 << s)];
				else
					stg[s+1][j] = stg[s][j];
			end
		end
		// Omega stages, position j pulls from j + 2^r
		for (int r = 0; r < `BX_ROT_STAGES; r++) begin
			for (int j = 0; j < `BX_NBANK; j++) begin
				if (i_cfg.rot_mask[r])
					stg[`BX_LANE_BW+r+1][j] = stg[`BX_LANE_BW+r][(j + (1 << r)) % `BX_NBANK];
				else
					stg[`BX_LANE_BW+r+1][j] = stg[`BX_LANE_BW+r][j];
			end
		end
	end

	assign o_banks = stg[NSTAGE];

endmodule

`default_nettype wire

//--- verilog/bank_butterfly_read.sv
/*
 Bank to lane order for one row, the exact mirror of the write network.
 Rotations are undone from the highest stage down.
 The swaps are then applied again, since each one is its own inverse.
 The row must be the one the data was read from.
*/
`include "bank_xor_macros.svh"
`default_nettype none

module bank_butterfly_read
	import bank_xor_pkg::*;
(
	input  wire xor_cfg_t              i_cfg,
	input  wire [`BX_ROW_BW-1:0]       i_row,
	input  wire lane_vec_t             i_banks,
	output lane_vec_t                  o_lanes
);

	//============================================================
	// Stage vectors
	//============================================================
	localparam int NSTAGE = `BX_ROT_STAGES + `BX_LANE_BW;

	lane_vec_t stg [NSTAGE+1];
	// Same row decode as the write side
	logic [`BX_LANE_BW-1:0] swap_en;

	always_comb begin
		for (int s = 0; s < `BX_LANE_BW; s++) begin
			swap_en[s] = i_row[i_cfg.swap_sel[s]];
		end
	end

	//============================================================
	// Inverse network
	//============================================================
	always_comb begin
		stg[0] = i_banks;
		// Undo omega stages, high to low
		// position j pulls from j - 2^r, kept positive before the modulo
		for (int k = 0; k < `BX_ROT_STAGES; k++) begin
			for (int j = 0; j < `BX_NBANK; j++) begin
				if (i_cfg.rot_mask[`BX_ROT_STAGES-1-k])
					stg[k+1][j] = stg[k][(j + `BX_NBANK - (1 << (`BX_ROT_STAGES-1-k))) % `BX_NBANK];
				else
					stg[k+1][j] = stg[k][j];
			end
		end
		// Swaps commute, so low to high is fine here too
		for (int s = 0; s < `BX_LANE_BW; s++) begin
			for (int j = 0; j < `BX_NBANK; j++) begin
				if (swap_en[s])
					stg[`BX_ROT_STAGES+s+1][j] = stg[`BX_ROT_STAGES+s][j ^ (1 << s)];
				else
					stg[`BX_ROT_STAGES+s+1][j] = stg[`BX_ROT_STAGES+s][j];
			end
		end
	end

	assign o_lanes = stg[NSTAGE];

endmodule

`default_nettype wire

//--- verilog/bank_sram_array.sv
/*
 Eight single-port banks, all addressed by the same row.
 A write stores every bank in one cycle.
 Read data and its row are registered at the read edge.
 Read and write in the same cycle are not allowed.
*/
`include "bank_xor_macros.svh"
`default_nettype none

module bank_sram_array
	import bank_xor_pkg::*;
(
	input  wire                        i_clk,
	input  wire                        i_arst_n,
	input  wire                        i_wr_en,
	input  wire                        i_rd_en,
	input  wire [`BX_ROW_BW-1:0]       i_row,
	input  wire lane_vec_t             i_wr_banks,
	output lane_vec_t                  o_rd_banks,
	output logic [`BX_ROW_BW-1:0]      o_rd_row
);

	localparam int NROWS = 1 << `BX_ROW_BW;

	//============================================================
	// Banks
	//============================================================
	for (genvar b = 0; b < `BX_NBANK; b++) begin : g_bank
		logic [`BX_DATA_BW-1:0] mem [NROWS];
		logic [`BX_DATA_BW-1:0] rd_q;

		// One port, write has priority over read
		always_ff @(posedge i_clk) begin
			if (i_wr_en)
				mem[i_row] <= i_wr_banks[b];
			else if (i_rd_en)
				rd_q <= mem[i_row];
		end

		assign o_rd_banks[b] = rd_q;
	end

	// Row of the last read, the read network needs it
	always_ff @(posedge i_clk) begin
		if (i_rd_en)
			o_rd_row <= i_row;
	end

	// Single port, so the caller must keep reads and writes apart
	a_no_rd_wr: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_wr_en && i_rd_en));

endmodule

`default_nettype wire

//--- verilog/bank_xor_ctrl.sv
/*
 Active configuration and read pipeline tracking.
 A new configuration applies from the cycle after its strobe.
 Read data leaves two edges after the read strobe.
 A configuration strobe must not share a cycle with a read strobe.
 There is no back-pressure and the output is never stalled.
*/
`default_nettype none

module bank_xor_ctrl
	import bank_xor_pkg::*;
(
	input  wire                        i_clk,
	input  wire                        i_arst_n,
	input  wire                        i_cfg_valid,
	input  wire xor_cfg_t              i_cfg,
	input  wire                        i_rd_valid,
	input  wire lane_vec_t             i_rd_lanes,
	output xor_cfg_t                   o_cfg,
	output logic                       o_rd_valid,
	output lane_vec_t                  o_rd_data
);

	//============================================================
	// Configuration
	//============================================================
	// Zero is the identity placement
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_cfg <= '0;
		else if (i_cfg_valid)
			o_cfg <= i_cfg;
	end

	//============================================================
	// Read pipeline
	//============================================================
	// Bit 0 marks bank data captured, bit 1 the output register
	logic [1:0] rd_vld_pipe;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			rd_vld_pipe <= '0;
		else
			rd_vld_pipe <= {rd_vld_pipe[0], i_rd_valid};
	end

	assign o_rd_valid = rd_vld_pipe[1];

	// Lane order vector, loaded while the inverse network holds it
	always_ff @(posedge i_clk) begin
		if (rd_vld_pipe[0])
			o_rd_data <= i_rd_lanes;
	end

	// Inverse network decodes in the cycle after the read strobe
	a_cfg_rd_apart: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_rd_valid |-> !i_cfg_valid);

endmodule

`default_nettype wire

//--- verilog/bank_xor_mem_top.sv
/*
 Banked vector scratchpad with XOR scrambled bank placement.
 Configuration, write and read are single-cycle strobes.
 A read and a write must not be issued in the same cycle.
 Read data returns two edges after the strobe, in lane order.
*/
`include "bank_xor_macros.svh"
`default_nettype none

module bank_xor_mem_top
	import bank_xor_pkg::*;
(
	input  wire                        i_clk,
	input  wire                        i_arst_n,
	input  wire                        i_cfg_valid,
	input  wire xor_cfg_t              i_cfg,
	input  wire                        i_wr_valid,
	input  wire wr_req_t               i_wr,
	input  wire                        i_rd_valid,
	input  wire rd_req_t               i_rd,
	output logic                       o_rd_valid,
	output lane_vec_t                  o_rd_data
);

	xor_cfg_t              cfg;
	lane_vec_t             wr_banks;
	lane_vec_t             rd_banks;
	lane_vec_t             rd_lanes;
	logic [`BX_ROW_BW-1:0] rd_row;
	logic [`BX_ROW_BW-1:0] row;

	// Shared port, only one request at a time
	assign row = i_wr_valid ? i_wr.row : i_rd.row;

	bank_xor_ctrl u_ctrl (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_cfg_valid(i_cfg_valid), .i_cfg(i_cfg),
		.i_rd_valid(i_rd_valid), .i_rd_lanes(rd_lanes),
		.o_cfg(cfg), .o_rd_valid(o_rd_valid), .o_rd_data(o_rd_data)
	);

	bank_butterfly_write u_bf_wr (
		.i_cfg(cfg), .i_row(i_wr.row), .i_lanes(i_wr.data), .o_banks(wr_banks)
	);

	bank_sram_array u_sram (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_wr_en(i_wr_valid), .i_rd_en(i_rd_valid), .i_row(row),
		.i_wr_banks(wr_banks), .o_rd_banks(rd_banks), .o_rd_row(rd_row)
	);

	// Works on the registered row, one cycle after the strobe
	bank_butterfly_read u_bf_rd (
		.i_cfg(cfg), .i_row(rd_row), .i_banks(rd_banks), .o_lanes(rd_lanes)
	);

endmodule

`default_nettype wire

//--- sim/bank_xor_mem_tb.sv
/*
 Directed testbench for the banked scratchpad.
 Inputs are driven on the falling edge and outputs sampled there too.
 The permutation model follows the lane placement rule and is used
 only by the cross configuration test.
*/
`include "bank_xor_macros.svh"
`default_nettype none

module bank_xor_mem_tb
	import bank_xor_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// About five times the length of all tests together
	localparam int MAX_CYCLES = 400;
	localparam int NROWS = 1 << `BX_ROW_BW;

	logic      clk;
	logic      i_arst_n;
	logic      i_cfg_valid;
	xor_cfg_t  i_cfg;
	logic      i_wr_valid;
	wr_req_t   i_wr;
	logic      i_rd_valid;
	rd_req_t   i_rd;
	logic      o_rd_valid;
	lane_vec_t o_rd_data;

	int        seed;
	int        cycles;
	int        errors;
	int        tests_run;
	int        tests_failed;
	lane_vec_t store [NROWS];

	bank_xor_mem_top u_dut (
		.i_clk(clk), .i_arst_n(i_arst_n),
		.i_cfg_valid(i_cfg_valid), .i_cfg(i_cfg),
		.i_wr_valid(i_wr_valid), .i_wr(i_wr),
		.i_rd_valid(i_rd_valid), .i_rd(i_rd),
		.o_rd_valid(o_rd_valid), .o_rd_data(o_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Ends a run that stops making progress
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("sim failed");
		$finish;
	end

	//============================================================
	// Reference permutation model
	//============================================================
	// Lane order to bank order for one row
	function automatic lane_vec_t place_lanes(input xor_cfg_t c,
			input logic [`BX_ROW_BW-1:0] row, input lane_vec_t v);
		lane_vec_t cur;
		lane_vec_t nxt;
		cur = v;
		for (int s = 0; s < `BX_LANE_BW; s++) begin
			if (row[c.swap_sel[s]]) begin
				for (int j = 0; j < `BX_NBANK; j++)
					nxt[j] = cur[j ^ (1 << s)];
				cur = nxt;
			end
		end
		for (int r = 0; r < `BX_ROT_STAGES; r++) begin
			if (c.rot_mask[r]) begin
				for (int j = 0; j < `BX_NBANK; j++)
					nxt[j] = cur[(j + (1 << r)) % `BX_NBANK];
				cur = nxt;
			end
		end
		return cur;
	endfunction

	// Bank order back to lane order, rotations pushed back then swaps
	function automatic lane_vec_t unplace_banks(input xor_cfg_t c,
			input logic [`BX_ROW_BW-1:0] row, input lane_vec_t v);
		lane_vec_t cur;
		lane_vec_t nxt;
		cur = v;
		for (int r = `BX_ROT_STAGES - 1; r >= 0; r--) begin
			if (c.rot_mask[r]) begin
				for (int j = 0; j < `BX_NBANK; j++)
					nxt[(j + (1 << r)) % `BX_NBANK] = cur[j];
				cur = nxt;
			end
		end
		for (int s = 0; s < `BX_LANE_BW; s++) begin
			if (row[c.swap_sel[s]]) begin
				for (int j = 0; j < `BX_NBANK; j++)
					nxt[j] = cur[j ^ (1 << s)];
				cur = nxt;
			end
		end
		return cur;
	endfunction

	//============================================================
	// Helpers
	//============================================================
	function automatic xor_cfg_t make_cfg(input logic [1:0] s0, input logic [1:0] s1,
			input logic [1:0] s2, input logic [2:0] mask);
		xor_cfg_t c;
		c.swap_sel[0] = s0;
		c.swap_sel[1] = s1;
		c.swap_sel[2] = s2;
		c.rot_mask = mask;
		return c;
	endfunction

	task automatic random_vec(output lane_vec_t v);
		logic [31:0] word;
		for (int l = 0; l < `BX_NBANK; l++) begin
			word = $random(seed);
			v[l] = word[`BX_DATA_BW-1:0];
		end
	endtask

	task automatic check_vec(input string sig, input lane_vec_t exp, input lane_vec_t got);
		assert (got === exp) else begin
			$display("Error t=%0t %s expected %h got %h", $time, sig, exp, got);
			errors++;
		end
	endtask

	task automatic check_bit(input string sig, input logic exp, input logic got);
		assert (got === exp) else begin
			$display("Error t=%0t %s expected %b got %b", $time, sig, exp, got);
			errors++;
		end
	endtask

	// All drive tasks start and end on a falling edge
	task automatic load_cfg(input xor_cfg_t c);
		i_cfg_valid = 1'b1;
		i_cfg = c;
		@(negedge clk);
		i_cfg_valid = 1'b0;
	endtask

	task automatic write_row(input logic [`BX_ROW_BW-1:0] row, input lane_vec_t v);
		i_wr_valid = 1'b1;
		i_wr.row = row;
		i_wr.data = v;
		@(negedge clk);
		i_wr_valid = 1'b0;
	endtask

	// Waits for o_rd_valid, counting edges since the strobe
	task automatic read_row(input logic [`BX_ROW_BW-1:0] row, input lane_vec_t exp);
		int lat;
		i_rd_valid = 1'b1;
		i_rd.row = row;
		@(negedge clk);
		i_rd_valid = 1'b0;
		lat = 1;
		while (!o_rd_valid && lat < 8) begin
			@(negedge clk);
			lat++;
		end
		assert (o_rd_valid) else begin
			$display("Read of row %0d never returned valid data", row);
			errors++;
		end
		assert (lat == 2) else begin
			$display("Error t=%0t o_rd_valid latency expected 2 got %0d", $time, lat);
			errors++;
		end
		check_vec("o_rd_data", exp, o_rd_data);
	endtask

	task automatic report(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - err_before);
		end
	endtask

	//============================================================
	// Tests
	//============================================================
	task automatic test_identity();
		int e;
		lane_vec_t v;
		e = errors;
		repeat (3) begin
			check_bit("o_rd_valid", 1'b0, o_rd_valid);
			@(negedge clk);
		end
		random_vec(v);
		write_row(4'd5, v);
		read_row(4'd5, v);
		report("identity", e);
	endtask

	task automatic test_all_rows();
		int e;
		e = errors;
		load_cfg(make_cfg(2'd2, 2'd0, 2'd3, 3'b111));
		for (int r = 0; r < NROWS; r++) begin
			random_vec(store[r]);
			write_row(r[`BX_ROW_BW-1:0], store[r]);
		end
		for (int r = 0; r < NROWS; r++)
			read_row(r[`BX_ROW_BW-1:0], store[r]);
		report("all_rows", e);
	endtask

	// Four reads in a row, outputs expected at positions 2 to 5
	task automatic test_back_to_back();
		int e;
		e = errors;
		@(negedge clk);
		for (int c = 0; c < 8; c++) begin
			if (c >= 2 && c < 6) begin
				check_bit("o_rd_valid", 1'b1, o_rd_valid);
				check_vec("o_rd_data", store[c-2], o_rd_data);
			end else begin
				check_bit("o_rd_valid", 1'b0, o_rd_valid);
			end
			i_rd_valid = (c < 4);
			i_rd.row = c[`BX_ROW_BW-1:0];
			@(negedge clk);
		end
		report("back_to_back", e);
	endtask

	task automatic test_cross_cfg();
		int e;
		xor_cfg_t ca;
		xor_cfg_t cb;
		lane_vec_t v;
		e = errors;
		ca = make_cfg(2'd1, 2'd2, 2'd0, 3'b101);
		cb = make_cfg(2'd3, 2'd3, 2'd1, 3'b010);
		random_vec(v);
		load_cfg(ca);
		write_row(4'd9, v);
		load_cfg(cb);
		read_row(4'd9, unplace_banks(cb, 4'd9, place_lanes(ca, 4'd9, v)));
		report("cross_cfg", e);
	endtask

	// Write lands in the cycle right after the configuration strobe
	task automatic test_cfg_next_cycle();
		int e;
		lane_vec_t v;
		e = errors;
		random_vec(v);
		i_cfg_valid = 1'b1;
		i_cfg = make_cfg(2'd0, 2'd1, 2'd2, 3'b011);
		@(negedge clk);
		i_cfg_valid = 1'b0;
		write_row(4'd6, v);
		read_row(4'd6, v);
		report("cfg_next_cycle", e);
	endtask

	//============================================================
	// Main sequence
	//============================================================
	initial begin
		seed = 30;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		i_arst_n = 1'b0;
		i_cfg_valid = 1'b0;
		i_cfg = '0;
		i_wr_valid = 1'b0;
		i_wr = '0;
		i_rd_valid = 1'b0;
		i_rd = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		i_arst_n = 1'b1;

		test_identity();
		test_all_rows();
		test_back_to_back();
		test_cross_cfg();
		test_cfg_next_cycle();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bank_xor_mem.f
+incdir+include
verilog/bank_xor_pkg.sv
verilog/bank_butterfly_write.sv
verilog/bank_butterfly_read.sv
verilog/bank_sram_array.sv
verilog/bank_xor_ctrl.sv
verilog/bank_xor_mem_top.sv
sim/bank_xor_mem_tb.sv

//--- Makefile
# Verilator build and run for the banked scratchpad

VERILATOR ?= verilator
TOP       ?= bank_xor_mem_tb
FLIST     ?= bank_xor_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
